// ==== all.f ====
+incdir+include
source/serdes_reg_pkg.sv
source/cpu_bus_port.sv
source/qpll_reg_bank.sv
source/channel_reg_bank.sv
source/serdes_cpu_if.sv
test/tb_serdes_cpu_if.sv

// ==== Makefile ====
# Verilator lint and simulation of the SerDes CPU register interface

TOP := tb_serdes_cpu_if

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f $(wildcard source/*.sv include/*.svh test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir

clean:
	rm -rf obj_dir

// ==== include/tb_reg_model.svh ====
`ifndef TB_REG_MODEL_SVH
`define TB_REG_MODEL_SVH
// -------------------------------------
// Register reference model
// Shadow config and alarm words, address
// helpers and expected read data
// -------------------------------------
import serdes_reg_pkg::*;

qpll_words_t    [qpll_count-1:0]    model_qpll_cfg;
channel_words_t [channel_count-1:0] model_chan_cfg;
channel_words_t [channel_count-1:0] model_alarm;   // Expected sticky latches

function automatic word_t qpll_addr(int unsigned slot, int unsigned word, bit state);
    return 16'(reg_base_addr + qpll_block_offset + slot * qpll_stride
               + (state ? qpll_state_offset : 0) + 2 * word);
endfunction

function automatic word_t chan_addr(int unsigned ch, chan_group_e grp, int unsigned word);
    return {8'(reg_base_addr[15:8] + channel_block_hi + ch), 8'(grp + 2 * word)};
endfunction

function automatic void model_reset();
    for (int s = 0; s < qpll_count; s++)
        model_qpll_cfg[s] = qpll_words_t'(qpll_reset_word0);
    for (int c = 0; c < channel_count; c++)
        model_chan_cfg[c] = channel_reset_cfg;
    model_alarm = '0;
endfunction

// Expected read word, zero for unmapped or odd addresses
function automatic word_t model_read(word_t addr,
    qpll_words_t [qpll_count-1:0] q_state, channel_words_t [channel_count-1:0] c_state);
    int unsigned rel;
    int unsigned off;
    int unsigned ch;
    rel = 32'(word_t'(addr - reg_base_addr));
    if (rel[0])
        return '0;
    if (rel >= qpll_block_offset && rel < qpll_block_offset + qpll_count * qpll_stride)
    begin
        ch  = (rel - qpll_block_offset) / qpll_stride;
        off = (rel - qpll_block_offset) % qpll_stride;
        if (off < 2 * qpll_words)
            return model_qpll_cfg[ch][off / 2];
        if (off >= qpll_state_offset && off < qpll_state_offset + 2 * qpll_words)
            return q_state[ch][(off - qpll_state_offset) / 2];
        return '0;
    end
    ch  = rel[15:8] - channel_block_hi;
    off = rel[7:0];
    if (rel[15:8] < channel_block_hi || ch >= channel_count)
        return '0;
    if (off < CHAN_CFG + 2 * channel_words)
        return model_chan_cfg[ch][off / 2];
    if (off >= CHAN_STATE && off < CHAN_STATE + 2 * channel_words)
        return c_state[ch][(off - CHAN_STATE) / 2];
    if (off >= CHAN_ALARM && off < CHAN_ALARM + 2 * channel_words)
        return model_alarm[ch][(off - CHAN_ALARM) / 2];
    return '0;
endfunction

`endif

// ==== test/tb_serdes_cpu_if.sv ====
`timescale 1ns/10ps
// ----------------------------------------
// SerDes CPU interface testbench
// Reset values, config writes, state and
// alarm readback, unmapped addresses
// ----------------------------------------
module tb_serdes_cpu_if;

    `include "tb_reg_model.svh"

    localparam int cfg_total       = qpll_count * qpll_words + channel_count * channel_words;
    localparam int alarm_total     = channel_count * channel_words;
    localparam int hole_count      = 8;
    localparam int access_total    = 4 * cfg_total + 2 * alarm_total + 2 * hole_count;
    localparam int watchdog_cycles = access_total * 10 + 1000;

    logic                               I_system_clk = 1'b0;
    logic                               I_system_rst;
    logic                               cpu_wren;
    logic                               cpu_rden;
    word_t                              cpu_addr;
    word_t                              cpu_wdat;
    word_t                              cpu_rdat;
    qpll_words_t    [qpll_count-1:0]    qpll_config;
    qpll_words_t    [qpll_count-1:0]    qpll_state;
    channel_words_t [channel_count-1:0] channel_config;
    channel_words_t [channel_count-1:0] channel_state;
    channel_words_t [channel_count-1:0] channel_alarm;
    integer                             seed = 32'h8a1e6e1a;
    word_t                              rd_addr;          // Address of the last read
    event                               read_done;

    // Odd offsets, unused words and pages with no bank behind them
    word_t holes [hole_count] = '{16'h0000, 16'h0401, 16'h0430, 16'h0801,
                                  16'h0814, 16'h0844, 16'h0874, 16'h1200};

    serdes_cpu_if u_dut
    (
        .I_system_clk   (I_system_clk),
        .I_system_rst   (I_system_rst),
        .cpu_wren       (cpu_wren),
        .cpu_rden       (cpu_rden),
        .cpu_addr       (cpu_addr),
        .cpu_wdat       (cpu_wdat),
        .cpu_rdat       (cpu_rdat),
        .qpll_config    (qpll_config),
        .qpll_state     (qpll_state),
        .channel_config (channel_config),
        .channel_state  (channel_state),
        .channel_alarm  (channel_alarm)
    );

    always #4 I_system_clk = ~I_system_clk;   // 8 ns period

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_word(input word_t exp, input word_t got, input string name);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            $display("Result: FAILED");
            $fatal(1, "Read data mismatch");
        end
    endtask

    task automatic check_qpll(input qpll_words_t exp, input qpll_words_t got,
                              input string name);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            $display("Result: FAILED");
            $fatal(1, "QPLL config mismatch");
        end
    endtask

    task automatic check_channel(input channel_words_t exp, input channel_words_t got,
                                 input string name);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
            $display("Result: FAILED");
            $fatal(1, "Channel config mismatch");
        end
    endtask

    // Expected read data comes from the model at the sampling point
    always @(read_done)
        check_word(model_read(rd_addr, qpll_state, channel_state), cpu_rdat,
                   $sformatf("cpu_rdat at %h", rd_addr));

    // ----------------------------------------
    // Bus tasks, called on a rising edge
    // ----------------------------------------
    task automatic write_reg(input word_t addr, input word_t data);
        cpu_addr <= addr;
        cpu_wdat <= data;
        cpu_wren <= 1'b1;
        repeat (8) @(posedge I_system_clk);
        cpu_wren <= 1'b0;
        repeat (2) @(posedge I_system_clk);   // Level low rearms the edge
    endtask

    task automatic read_reg(input word_t addr);
        cpu_addr <= addr;
        cpu_rden <= 1'b1;
        repeat (8) @(posedge I_system_clk);
        rd_addr = addr;
        -> read_done;                         // cpu_rdat settled at edge 5
        cpu_rden <= 1'b0;
        repeat (2) @(posedge I_system_clk);
    endtask

    task automatic check_config_outputs();
        for (int s = 0; s < qpll_count; s++)
            check_qpll(model_qpll_cfg[s], qpll_config[s], $sformatf("qpll_config[%0d]", s));
        for (int c = 0; c < channel_count; c++)
            check_channel(model_chan_cfg[c], channel_config[c],
                          $sformatf("channel_config[%0d]", c));
    endtask

    task automatic read_all_config();
        for (int s = 0; s < qpll_count; s++)
            for (int w = 0; w < qpll_words; w++)
                read_reg(qpll_addr(s, w, 1'b0));
        for (int c = 0; c < channel_count; c++)
            for (int w = 0; w < channel_words; w++)
                read_reg(chan_addr(c, CHAN_CFG, w));
    endtask

    task automatic write_all_config();
        word_t data;
        for (int s = 0; s < qpll_count; s++)
        begin
            for (int w = 0; w < qpll_words; w++)
            begin
                data = word_t'($random(seed));
                write_reg(qpll_addr(s, w, 1'b0), data);
                model_qpll_cfg[s][w] = data;
            end
        end
        for (int c = 0; c < channel_count; c++)
        begin
            for (int w = 0; w < channel_words; w++)
            begin
                data = word_t'($random(seed));
                write_reg(chan_addr(c, CHAN_CFG, w), data);
                model_chan_cfg[c][w] = data;
            end
        end
    endtask

    task automatic state_readback();
        for (int s = 0; s < qpll_count; s++)
            for (int w = 0; w < qpll_words; w++)
                qpll_state[s][w] <= word_t'($random(seed));
        for (int c = 0; c < channel_count; c++)
            for (int w = 0; w < channel_words; w++)
                channel_state[c][w] <= word_t'($random(seed));
        for (int s = 0; s < qpll_count; s++)
            for (int w = 0; w < qpll_words; w++)
                read_reg(qpll_addr(s, w, 1'b1));
        for (int c = 0; c < channel_count; c++)
            for (int w = 0; w < channel_words; w++)
                read_reg(chan_addr(c, CHAN_STATE, w));
    endtask

    // One pulse on every alarm input, then a sparse pattern held high
    task automatic alarm_readback();
        channel_words_t [channel_count-1:0] pulse;
        channel_words_t [channel_count-1:0] held;
        for (int c = 0; c < channel_count; c++)
        begin
            for (int w = 0; w < channel_words; w++)
            begin
                pulse[c][w] = word_t'($random(seed));
                held[c][w]  = word_t'($random(seed) & $random(seed));
            end
        end
        channel_alarm <= pulse;
        model_alarm = model_alarm | pulse;
        @(posedge I_system_clk);
        channel_alarm <= held;
        model_alarm = model_alarm | held;
        @(posedge I_system_clk);
        for (int c = 0; c < channel_count; c++)
        begin
            for (int w = 0; w < channel_words; w++)
            begin
                read_reg(chan_addr(c, CHAN_ALARM, w));
                model_alarm[c][w] = held[c][w];   // Live bits survive the clear
                read_reg(chan_addr(c, CHAN_ALARM, w));
            end
        end
        channel_alarm <= '0;
    endtask

    task automatic unmapped_access();
        for (int i = 0; i < hole_count; i++)
        begin
            write_reg(holes[i], word_t'($random(seed)));
            check_config_outputs();
            read_reg(holes[i]);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        I_system_rst  = 1'b1;
        cpu_wren      = 1'b0;
        cpu_rden      = 1'b0;
        cpu_addr      = '0;
        cpu_wdat      = '0;
        qpll_state    = '0;
        channel_state = '0;
        channel_alarm = '0;
        rd_addr       = '0;
        model_reset();
        repeat (16) @(posedge I_system_clk);
        I_system_rst <= 1'b0;
        @(posedge I_system_clk);

        read_all_config();      // Reset values
        check_config_outputs();
        write_all_config();
        read_all_config();
        check_config_outputs();
        state_readback();
        alarm_readback();
        unmapped_access();

        $display("Result: PASSED");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge I_system_clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== source/serdes_cpu_if.sv ====
`timescale 1ns/10ps
// -------------------------------------
// SerDes CPU register interface top
// Bus port, QPLL bank and one bank per
// channel
// -------------------------------------
module serdes_cpu_if
(
    input  logic                                                               I_system_clk,
    input  logic                                                               I_system_rst,
    input  logic                                                               cpu_wren,
    input  logic                                                               cpu_rden,
    input  serdes_reg_pkg::word_t                                              cpu_addr,
    input  serdes_reg_pkg::word_t                                              cpu_wdat,
    output serdes_reg_pkg::word_t                                              cpu_rdat,
    output serdes_reg_pkg::qpll_words_t    [serdes_reg_pkg::qpll_count-1:0]    qpll_config,
    input  serdes_reg_pkg::qpll_words_t    [serdes_reg_pkg::qpll_count-1:0]    qpll_state,
    output serdes_reg_pkg::channel_words_t [serdes_reg_pkg::channel_count-1:0] channel_config,
    input  serdes_reg_pkg::channel_words_t [serdes_reg_pkg::channel_count-1:0] channel_state,
    input  serdes_reg_pkg::channel_words_t [serdes_reg_pkg::channel_count-1:0] channel_alarm
);
    import serdes_reg_pkg::*;

    reg_access_t                    access;         // To every bank
    word_t                          qpll_rdat;
    wire word_t [channel_count-1:0] channel_rdat;   // One word per channel bank

    cpu_bus_port u_bus_port
    (
        .I_system_clk (I_system_clk),
        .I_system_rst (I_system_rst),
        .cpu_wren     (cpu_wren),
        .cpu_rden     (cpu_rden),
        .cpu_addr     (cpu_addr),
        .cpu_wdat     (cpu_wdat),
        .qpll_rdat    (qpll_rdat),
        .channel_rdat (channel_rdat),
        .access       (access),
        .cpu_rdat     (cpu_rdat)
    );

    qpll_reg_bank u_qpll_bank
    (
        .I_system_clk (I_system_clk),
        .I_system_rst (I_system_rst),
        .access       (access),
        .qpll_state   (qpll_state),
        .qpll_config  (qpll_config),
        .rdat         (qpll_rdat)
    );

    // -------------------------------------
    // Channel banks
    // -------------------------------------
    for (genvar c = 0; c < channel_count; c++)
    begin : g_chan
        channel_reg_bank #(.channel_index(c)) u_chan_bank
        (
            .I_system_clk (I_system_clk),
            .I_system_rst (I_system_rst),
            .access       (access),
            .chan_state   (channel_state[c]),
            .chan_alarm   (channel_alarm[c]),
            .chan_config  (channel_config[c]),
            .rdat         (channel_rdat[c])
        );
    end

endmodule

// ==== source/channel_reg_bank.sv ====
`timescale 1ns/10ps
// -------------------------------------
// Channel register bank
// Config, state readback and sticky
// alarm latches for one channel
// -------------------------------------
module channel_reg_bank
#(
    parameter int channel_index = 0
)
(
    input  logic                           I_system_clk,
    input  logic                           I_system_rst,
    input  serdes_reg_pkg::reg_access_t    access,
    input  serdes_reg_pkg::channel_words_t chan_state,
    input  serdes_reg_pkg::channel_words_t chan_alarm,
    output serdes_reg_pkg::channel_words_t chan_config,
    output serdes_reg_pkg::word_t          rdat
);
    import serdes_reg_pkg::*;

    logic [7:0]     lo;         // Low address byte
    logic [7:0]     grp_off;    // Byte offset from group base
    logic [6:0]     word_idx;
    chan_group_e    grp;
    logic           page_hit;
    logic           hit;
    logic           rd_clear;
    channel_words_t alarm_latch;

    // -------------------------------------
    // Address decode
    // -------------------------------------
    always_comb
    begin
        lo = access.addr[7:0];
        if (lo >= CHAN_ALARM)
            grp = CHAN_ALARM;
        else if (lo >= CHAN_STATE)
            grp = CHAN_STATE;
        else
            grp = CHAN_CFG;
        grp_off  = lo - grp;
        word_idx = grp_off[7:1];
        page_hit = access.addr[15:8]
                   == 8'(reg_base_addr[15:8] + channel_block_hi + channel_index);
        hit      = page_hit && !grp_off[0] && (word_idx < channel_words);
        rd_clear = access.rd && hit && (grp == CHAN_ALARM);
    end

    // Config registers
    always_ff @(posedge I_system_clk or posedge I_system_rst)
    begin
        if (I_system_rst)
            chan_config <= channel_reset_cfg;
        else if (access.wr && hit && (grp == CHAN_CFG))
            chan_config[word_idx] <= access.wdat;
    end

    // -------------------------------------
    // Sticky alarms
    // -------------------------------------
    always_ff @(posedge I_system_clk or posedge I_system_rst)
    begin
        if (I_system_rst)
            alarm_latch <= '0;
        else
        begin
            for (int w = 0; w < channel_words; w++)
            begin
                if (rd_clear && (word_idx == w))
                    alarm_latch[w] <= chan_alarm[w];  // Live input beats the clear
                else
                    alarm_latch[w] <= alarm_latch[w] | chan_alarm[w];
            end
        end
    end

    // Read word, zero outside this channel page
    always_ff @(posedge I_system_clk)
    begin
        if (access.rd)
        begin
            if (!hit)
                rdat <= '0;
            else
            begin
                case (grp)
                    CHAN_CFG:   rdat <= chan_config[word_idx];
                    CHAN_STATE: rdat <= chan_state[word_idx];
                    default:    rdat <= alarm_latch[word_idx];  // Value before clear
                endcase
            end
        end
    end

    // A raised alarm bit is never lost, even across a read-clear
    assert property (@(posedge I_system_clk) disable iff (I_system_rst)
        chan_alarm != '0 |=> (alarm_latch & $past(chan_alarm)) == $past(chan_alarm))
        else $error("Alarm bit not latched in channel %0d", channel_index);

endmodule

// ==== source/qpll_reg_bank.sv ====
`timescale 1ns/10ps
// -------------------------------------
// QPLL register bank
// Config words and state readback for
// every QPLL common
// -------------------------------------
module qpll_reg_bank
(
    input  logic                                                         I_system_clk,
    input  logic                                                         I_system_rst,
    input  serdes_reg_pkg::reg_access_t                                  access,
    input  serdes_reg_pkg::qpll_words_t [serdes_reg_pkg::qpll_count-1:0] qpll_state,
    output serdes_reg_pkg::qpll_words_t [serdes_reg_pkg::qpll_count-1:0] qpll_config,
    output serdes_reg_pkg::word_t                                        rdat
);
    import serdes_reg_pkg::*;

    word_t       rel;       // Offset from the QPLL block base
    word_t       slot_off;  // Byte offset inside one slot
    int unsigned slot;
    int unsigned word_idx;
    logic        is_state;
    logic        hit;

    // -------------------------------------
    // Address decode
    // -------------------------------------
    always_comb
    begin
        rel      = access.addr - reg_base_addr - qpll_block_offset;  // Wraps high below block
        slot     = 32'(rel / qpll_stride);
        slot_off = rel % qpll_stride;
        is_state = slot_off >= qpll_state_offset;
        if (is_state)
            word_idx = 32'(slot_off - 16'(qpll_state_offset)) / 2;
        else
            word_idx = 32'(slot_off) / 2;
        hit = (slot < qpll_count) && (word_idx < qpll_words) && !slot_off[0];
    end

    // Config registers
    always_ff @(posedge I_system_clk or posedge I_system_rst)
    begin
        if (I_system_rst)
        begin
            for (int s = 0; s < qpll_count; s++)
                qpll_config[s] <= qpll_words_t'(qpll_reset_word0);  // Upper words zero
        end
        else if (access.wr && hit && !is_state)
            qpll_config[slot][word_idx] <= access.wdat;
    end

    // Read word, zero when the address is not ours
    always_ff @(posedge I_system_clk)
    begin
        if (access.rd)
        begin
            if (!hit)
                rdat <= '0;
            else if (is_state)
                rdat <= qpll_state[slot][word_idx];
            else
                rdat <= qpll_config[slot][word_idx];
        end
    end

    // Keeps the OR in the bus port clean
    assert property (@(posedge I_system_clk) disable iff (I_system_rst)
        access.rd && (rel >= 16'(qpll_count) * qpll_stride) |=> rdat == '0)
        else $error("QPLL bank returned data outside its block");

endmodule

// ==== source/cpu_bus_port.sv ====
`timescale 1ns/10ps
// -------------------------------------
// CPU bus port
// Syncs host enables, issues one-cycle
// accesses, registers the read data
// -------------------------------------
module cpu_bus_port
(
    input  logic                                                      I_system_clk,
    input  logic                                                      I_system_rst,
    input  logic                                                      cpu_wren,
    input  logic                                                      cpu_rden,
    input  serdes_reg_pkg::word_t                                     cpu_addr,
    input  serdes_reg_pkg::word_t                                     cpu_wdat,
    input  serdes_reg_pkg::word_t                                     qpll_rdat,
    input  serdes_reg_pkg::word_t [serdes_reg_pkg::channel_count-1:0] channel_rdat,
    output serdes_reg_pkg::reg_access_t                               access,
    output serdes_reg_pkg::word_t                                     cpu_rdat
);
    import serdes_reg_pkg::*;

    logic [2:0] wren_sync;  // Oldest sample in bit 2
    logic [2:0] rden_sync;
    logic       wr_edge;
    logic       rd_edge;
    logic       acc_wr;
    logic       acc_rd;
    word_t      acc_addr;
    word_t      acc_wdat;
    logic       rd_dly;     // Bank read words valid
    word_t      rdat_any;

    assign wr_edge = wren_sync[1] & ~wren_sync[2];
    assign rd_edge = rden_sync[1] & ~rden_sync[2];

    assign access = '{wr: acc_wr, rd: acc_rd, addr: acc_addr, wdat: acc_wdat};

    // -------------------------------------
    // Synchronizers and strobes
    // -------------------------------------
    always_ff @(posedge I_system_clk or posedge I_system_rst)
    begin
        if (I_system_rst)
        begin
            wren_sync <= '0;
            rden_sync <= '0;
            acc_wr    <= 1'b0;
            acc_rd    <= 1'b0;
            rd_dly    <= 1'b0;
        end
        else
        begin
            wren_sync <= {wren_sync[1:0], cpu_wren};
            rden_sync <= {rden_sync[1:0], cpu_rden};
            acc_wr    <= wr_edge;   // One pulse per rising level
            acc_rd    <= rd_edge;
            rd_dly    <= acc_rd;
        end
    end

    // Host holds address and data stable well past the edge
    always_ff @(posedge I_system_clk)
    begin
        if (wr_edge || rd_edge)
        begin
            acc_addr <= cpu_addr;
            acc_wdat <= cpu_wdat;
        end
    end

    // -------------------------------------
    // Read return
    // -------------------------------------
    always_comb
    begin
        rdat_any = qpll_rdat;   // Non-addressed banks return zero
        for (int c = 0; c < channel_count; c++)
            rdat_any = rdat_any | channel_rdat[c];
    end

    always_ff @(posedge I_system_clk or posedge I_system_rst)
    begin
        if (I_system_rst)
            cpu_rdat <= '0;
        else if (rd_dly)
            cpu_rdat <= rdat_any;
    end

    // Host must not raise both enables together
    assert property (@(posedge I_system_clk) disable iff (I_system_rst)
        !(acc_wr && acc_rd))
        else $error("Write and read strobes in the same cycle");

endmodule

// ==== source/serdes_reg_pkg.sv ====
// -------------------------------------
// SerDes CPU register package
// Address map, counts, reset values and
// the access type shared by all banks
// -------------------------------------
package serdes_reg_pkg;

    typedef logic [15:0] word_t;

    // -------------------------------------
    // Sizes
    // -------------------------------------
    localparam word_t reg_base_addr = 16'h0000;
    localparam int    qpll_count    = 3;
    localparam int    qpll_words    = 4;
    localparam int    channel_count = 10;
    localparam int    channel_words = 10;

    typedef word_t [qpll_words-1:0]    qpll_words_t;     // One QPLL common
    typedef word_t [channel_words-1:0] channel_words_t;  // One channel group

    // -------------------------------------
    // Address map
    // -------------------------------------
    localparam word_t      qpll_block_offset = 16'h0400;
    localparam word_t      qpll_stride       = 16'h0010;  // One slot per common
    localparam int         qpll_state_offset = 8;         // State words after config
    localparam logic [7:0] channel_block_hi  = 8'h08;     // Page of channel 0

    // Low byte group bases inside a channel page, word w at base + 2w
    typedef enum logic [7:0]
    {
        CHAN_CFG   = 8'h00,
        CHAN_STATE = 8'h30,
        CHAN_ALARM = 8'h60
    } chan_group_e;

    // -------------------------------------
    // Reset values
    // -------------------------------------
    localparam word_t qpll_reset_word0 = 16'h0110;

    localparam channel_words_t channel_reset_cfg =
    {
        16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
        16'h0031, 16'h0550, 16'h9100, 16'h000c, 16'h0000
    };

    // Single-cycle access from the bus port to every bank
    typedef struct packed
    {
        logic  wr;
        logic  rd;
        word_t addr;
        word_t wdat;
    } reg_access_t;

endpackage
